// ==== include/tetris_defs.svh ====
// tetris core constants
`ifndef TETRIS_DEFS_SVH
`define TETRIS_DEFS_SVH

// playfield geometry, row 0 at the top
`define PLAYFIELD_ROWS 20
`define PLAYFIELD_COLS 10
`define ROW_W 5
`define COL_W 4

// origin of a freshly spawned piece
`define SPAWN_ROW 1
`define SPAWN_COL 4

// action cooldown, short enough for simulation
`define COOLDOWN_CYCLES 16
`define CD_W 8

// wishbone read port
`define WB_ADR_W 9
`define WB_DAT_W 8

`endif

// ==== source/tetris_pkg.sv ====
// tetris core types
`include "tetris_defs.svh"

package tetris_pkg;

    typedef enum logic [3:0] {
        BLANK = 4'd0,
        I     = 4'd1,
        O     = 4'd2,
        T     = 4'd3,
        S     = 4'd4,
        Z     = 4'd5,
        J     = 4'd6,
        L     = 4'd7
    } tile_type_t;

    typedef logic [`ROW_W-1:0] row_t;
    typedef logic [`COL_W-1:0] col_t;

    // offsets span -1 to 2
    typedef logic signed [2:0] offset_t;

    typedef struct packed {
        offset_t [0:3] row;
        offset_t [0:3] col;
    } piece_offsets_t;

    // spawn orientation only
    function automatic piece_offsets_t cell_offsets(input tile_type_t kind);
        piece_offsets_t o;
        o = '0;
        case (kind)
            I: begin
                o.row = {3'sd0, 3'sd0, 3'sd0, 3'sd0};
                o.col = {-3'sd1, 3'sd0, 3'sd1, 3'sd2};
            end
            O: begin
                o.row = {3'sd0, 3'sd0, 3'sd1, 3'sd1};
                o.col = {3'sd0, 3'sd1, 3'sd0, 3'sd1};
            end
            T: begin
                o.row = {3'sd0, 3'sd0, 3'sd0, -3'sd1};
                o.col = {-3'sd1, 3'sd0, 3'sd1, 3'sd0};
            end
            S: begin
                o.row = {3'sd0, 3'sd0, -3'sd1, -3'sd1};
                o.col = {-3'sd1, 3'sd0, 3'sd0, 3'sd1};
            end
            Z: begin
                o.row = {-3'sd1, -3'sd1, 3'sd0, 3'sd0};
                o.col = {-3'sd1, 3'sd0, 3'sd0, 3'sd1};
            end
            J: begin
                o.row = {-3'sd1, 3'sd0, 3'sd0, 3'sd0};
                o.col = {-3'sd1, -3'sd1, 3'sd0, 3'sd1};
            end
            L: begin
                o.row = {-3'sd1, 3'sd0, 3'sd0, 3'sd0};
                o.col = {3'sd1, -3'sd1, 3'sd0, 3'sd1};
            end
            default: o = '0;
        endcase
        return o;
    endfunction

endpackage

// ==== source/input_conditioner.sv ====
// key conditioning and action pulses
`timescale 1ns/1ps
`include "tetris_defs.svh"

module input_conditioner (
    input  logic clk,
    input  logic rst_l,
    input  logic key_left,
    input  logic key_right,
    input  logic key_soft,
    input  logic key_hard,
    input  logic left_valid,
    input  logic right_valid,
    output logic move_left,
    output logic move_right,
    output logic soft_drop,
    output logic hard_drop
);

    localparam logic [`CD_W-1:0] CD_LOAD = `COOLDOWN_CYCLES;

    // action index: 0 left, 1 right, 2 soft, 3 hard
    logic [3:0]        key_pressed;
    logic [3:0]        key_meta;
    logic [3:0]        key_sync;
    logic [`CD_W-1:0]  cooldown [4];
    logic [3:0]        armed;
    logic [3:0]        fire;
    logic [3:0]        pulse;

    assign key_pressed = {~key_hard, ~key_soft, ~key_right, ~key_left};

    // two-flop synchronizers
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            key_meta <= '0;
            key_sync <= '0;
        end else begin
            key_meta <= key_pressed;
            key_sync <= key_meta;
        end
    end

    // nothing fires while any pulse is in flight, so validity and
    // the landing row always refer to the piece as it stands
    always_comb begin
        for (int a = 0; a < 4; a++) begin
            armed[a] = key_sync[a] && (cooldown[a] == '0) && (pulse == '0);
        end
        fire[1] = armed[1] && right_valid;
        // right wins a tie
        fire[0] = armed[0] && left_valid && !fire[1];
        fire[2] = armed[2];
        fire[3] = armed[3];
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            pulse <= '0;
        end else begin
            pulse <= fire;
        end
    end

    for (genvar a = 0; a < 4; a++) begin : g_cooldown
        always_ff @(posedge clk or negedge rst_l) begin
            if (!rst_l) begin
                cooldown[a] <= '0;
            end else if (pulse[a]) begin
                cooldown[a] <= CD_LOAD;
            end else if (cooldown[a] != '0) begin
                cooldown[a] <= cooldown[a] - 1'b1;
            end
        end
    end

    assign move_left  = pulse[0];
    assign move_right = pulse[1];
    assign soft_drop  = pulse[2];
    assign hard_drop  = pulse[3];

endmodule

// ==== source/move_validator.sv ====
// collision checks for the falling piece
`timescale 1ns/1ps
`include "tetris_defs.svh"

module move_validator (
    input  tetris_pkg::row_t       origin_row,
    input  tetris_pkg::col_t       origin_col,
    input  tetris_pkg::tile_type_t piece_type,
    input  tetris_pkg::tile_type_t locked_cells [`PLAYFIELD_ROWS][`PLAYFIELD_COLS],
    output logic                   left_valid,
    output logic                   right_valid,
    output logic                   down_valid,
    output tetris_pkg::row_t       landing_row
);

    import tetris_pkg::*;

    // true when all four cells sit inside the field on blank cells
    function automatic logic piece_fits(input int org_r, input int org_c);
        piece_offsets_t offs;
        int             r;
        int             c;
        logic           ok;
        offs = cell_offsets(piece_type);
        ok   = 1'b1;
        for (int i = 0; i < 4; i++) begin
            r = org_r + int'($signed(offs.row[i]));
            c = org_c + int'($signed(offs.col[i]));
            if (r < 0 || r >= `PLAYFIELD_ROWS || c < 0 || c >= `PLAYFIELD_COLS) begin
                ok = 1'b0;
            end else if (locked_cells[r][c] != BLANK) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    always_comb begin
        left_valid  = piece_fits(int'(origin_row), int'(origin_col) - 1);
        right_valid = piece_fits(int'(origin_row), int'(origin_col) + 1);
        down_valid  = piece_fits(int'(origin_row) + 1, int'(origin_col));
    end

    // walk down until the first blocked row
    always_comb begin
        logic blocked;
        blocked     = 1'b0;
        landing_row = origin_row;
        for (int k = 1; k < `PLAYFIELD_ROWS; k++) begin
            if (!blocked && piece_fits(int'(origin_row) + k, int'(origin_col))) begin
                landing_row = row_t'(int'(origin_row) + k);
            end else begin
                blocked = 1'b1;
            end
        end
    end

endmodule

// ==== source/falling_piece.sv ====
// falling piece state and sequencing
`timescale 1ns/1ps
`include "tetris_defs.svh"

module falling_piece (
    input  logic                   clk,
    input  logic                   rst_l,
    input  logic                   move_left,
    input  logic                   move_right,
    input  logic                   soft_drop,
    input  logic                   hard_drop,
    input  logic                   down_valid,
    input  tetris_pkg::row_t       landing_row,
    output tetris_pkg::row_t       origin_row,
    output tetris_pkg::col_t       origin_col,
    output tetris_pkg::tile_type_t piece_type,
    output logic                   lock
);

    import tetris_pkg::*;

    localparam row_t SPAWN_ROW = `SPAWN_ROW;
    localparam col_t SPAWN_COL = `SPAWN_COL;

    row_t row_q;
    col_t col_q;
    row_t landing_q;

    // fixed piece order
    function automatic tile_type_t next_type(input tile_type_t cur);
        tile_type_t nxt;
        case (cur)
            I:       nxt = O;
            O:       nxt = T;
            T:       nxt = S;
            S:       nxt = Z;
            Z:       nxt = J;
            J:       nxt = L;
            default: nxt = I;
        endcase
        return nxt;
    endfunction

    // hard drop locks at once, a blocked soft drop locks too
    assign lock = hard_drop || (soft_drop && !down_valid);

    // landing row from the cycle before the hard-drop pulse;
    // the piece cannot have moved in between
    always_ff @(posedge clk) begin
        landing_q <= landing_row;
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            row_q      <= SPAWN_ROW;
            col_q      <= SPAWN_COL;
            piece_type <= I;
        end else if (lock) begin
            row_q      <= SPAWN_ROW;
            col_q      <= SPAWN_COL;
            piece_type <= next_type(piece_type);
        end else if (soft_drop) begin
            row_q <= row_q + 1'b1;
        end else if (move_right) begin
            col_q <= col_q + 1'b1;
        end else if (move_left) begin
            col_q <= col_q - 1'b1;
        end
    end

    // during a hard-drop lock the piece is shown where it lands
    assign origin_row = hard_drop ? landing_q : row_q;
    assign origin_col = col_q;

endmodule

// ==== source/locked_playfield.sv ====
// locked cells and wishbone read port
`timescale 1ns/1ps
`include "tetris_defs.svh"

module locked_playfield (
    input  logic                   clk,
    input  logic                   rst_l,
    input  tetris_pkg::row_t       origin_row,
    input  tetris_pkg::col_t       origin_col,
    input  tetris_pkg::tile_type_t piece_type,
    input  logic                   lock,
    output tetris_pkg::tile_type_t locked_cells [`PLAYFIELD_ROWS][`PLAYFIELD_COLS],
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`WB_ADR_W-1:0]   wb_adr,
    input  logic [`WB_DAT_W-1:0]   wb_dat_i,
    output logic [`WB_DAT_W-1:0]   wb_dat_o,
    output logic                   wb_ack
);

    import tetris_pkg::*;

    piece_offsets_t      offs;
    int                  cell_r [4];
    int                  cell_c [4];
    logic [3:0]          cell_in;
    row_t                rd_row;
    col_t                rd_col;
    logic                rd_cover;
    tile_type_t          rd_tile;
    logic                wb_hit;
    logic [`WB_DAT_W-1:0] rd_data;

    // absolute cells of the falling piece
    always_comb begin
        offs = cell_offsets(piece_type);
        for (int i = 0; i < 4; i++) begin
            cell_r[i]  = int'(origin_row) + int'($signed(offs.row[i]));
            cell_c[i]  = int'(origin_col) + int'($signed(offs.col[i]));
            cell_in[i] = cell_r[i] >= 0 && cell_r[i] < `PLAYFIELD_ROWS &&
                         cell_c[i] >= 0 && cell_c[i] < `PLAYFIELD_COLS;
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            for (int r = 0; r < `PLAYFIELD_ROWS; r++) begin
                for (int c = 0; c < `PLAYFIELD_COLS; c++) begin
                    locked_cells[r][c] <= BLANK;
                end
            end
        end else if (lock) begin
            for (int i = 0; i < 4; i++) begin
                if (cell_in[i]) begin
                    locked_cells[cell_r[i]][cell_c[i]] <= piece_type;
                end
            end
        end
    end

    // address is {row, col}
    assign rd_row = wb_adr[`WB_ADR_W-1 -: `ROW_W];
    assign rd_col = wb_adr[`COL_W-1:0];

    // falling piece drawn over the locked cells
    always_comb begin
        rd_cover = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (cell_in[i] && cell_r[i] == int'(rd_row) && cell_c[i] == int'(rd_col)) begin
                rd_cover = 1'b1;
            end
        end
        if (int'(rd_row) >= `PLAYFIELD_ROWS || int'(rd_col) >= `PLAYFIELD_COLS) begin
            rd_tile = BLANK;
        end else if (rd_cover) begin
            rd_tile = piece_type;
        end else begin
            rd_tile = locked_cells[rd_row][rd_col];
        end
    end

    // single-cycle ack, writes complete with no effect on wb_dat_i
    assign wb_hit = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_hit && !wb_we) begin
            rd_data <= {{(`WB_DAT_W - 4){1'b0}}, rd_tile};
        end
    end

    assign wb_dat_o = rd_data;

endmodule

// ==== source/tetris_core.sv ====
// tetris falling piece core
`timescale 1ns/1ps
`include "tetris_defs.svh"

module tetris_core (
    input  logic                 clk,
    input  logic                 rst_l,
    input  logic                 key_left,
    input  logic                 key_right,
    input  logic                 key_soft,
    input  logic                 key_hard,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`WB_ADR_W-1:0] wb_adr,
    input  logic [`WB_DAT_W-1:0] wb_dat_i,
    output logic [`WB_DAT_W-1:0] wb_dat_o,
    output logic                 wb_ack
);

    import tetris_pkg::*;

    logic       move_left;
    logic       move_right;
    logic       soft_drop;
    logic       hard_drop;
    logic       left_valid;
    logic       right_valid;
    logic       down_valid;
    logic       lock;
    row_t       landing_row;
    row_t       origin_row;
    col_t       origin_col;
    tile_type_t piece_type;
    tile_type_t locked_cells [`PLAYFIELD_ROWS][`PLAYFIELD_COLS];

    input_conditioner input_conditioner_inst (
        .clk         (clk),
        .rst_l       (rst_l),
        .key_left    (key_left),
        .key_right   (key_right),
        .key_soft    (key_soft),
        .key_hard    (key_hard),
        .left_valid  (left_valid),
        .right_valid (right_valid),
        .move_left   (move_left),
        .move_right  (move_right),
        .soft_drop   (soft_drop),
        .hard_drop   (hard_drop)
    );

    move_validator move_validator_inst (
        .origin_row   (origin_row),
        .origin_col   (origin_col),
        .piece_type   (piece_type),
        .locked_cells (locked_cells),
        .left_valid   (left_valid),
        .right_valid  (right_valid),
        .down_valid   (down_valid),
        .landing_row  (landing_row)
    );

    falling_piece falling_piece_inst (
        .clk         (clk),
        .rst_l       (rst_l),
        .move_left   (move_left),
        .move_right  (move_right),
        .soft_drop   (soft_drop),
        .hard_drop   (hard_drop),
        .down_valid  (down_valid),
        .landing_row (landing_row),
        .origin_row  (origin_row),
        .origin_col  (origin_col),
        .piece_type  (piece_type),
        .lock        (lock)
    );

    locked_playfield locked_playfield_inst (
        .clk          (clk),
        .rst_l        (rst_l),
        .origin_row   (origin_row),
        .origin_col   (origin_col),
        .piece_type   (piece_type),
        .lock         (lock),
        .locked_cells (locked_cells),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack)
    );

endmodule

// ==== test/tetris_tb.sv ====
// tetris core testbench
`timescale 1ns/1ps
`include "tetris_defs.svh"

module tetris_tb;

    localparam int ROWS        = `PLAYFIELD_ROWS;
    localparam int COLS        = `PLAYFIELD_COLS;
    localparam int ADR_W       = `WB_ADR_W;
    localparam int ACK_TIMEOUT = 20;
    localparam int KEY_LEFT    = 0;
    localparam int KEY_RIGHT   = 1;
    localparam int KEY_SOFT    = 2;
    localparam int KEY_HARD    = 3;

    // spawn orientation offsets by tile type with blank in entry 0
    localparam int SHAPE_ROW [8][4] = '{
        '{0, 0, 0, 0},
        '{0, 0, 0, 0},
        '{0, 0, 1, 1},
        '{0, 0, 0, -1},
        '{0, 0, -1, -1},
        '{-1, -1, 0, 0},
        '{-1, 0, 0, 0},
        '{-1, 0, 0, 0}
    };
    localparam int SHAPE_COL [8][4] = '{
        '{0, 0, 0, 0},
        '{-1, 0, 1, 2},
        '{0, 1, 0, 1},
        '{-1, 0, 1, 0},
        '{-1, 0, 0, 1},
        '{-1, 0, 0, 1},
        '{-1, -1, 0, 1},
        '{1, -1, 0, 1}
    };

    logic             clk;
    logic             rst_l;
    logic [3:0]       keys_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [ADR_W-1:0] wb_adr;
    logic [7:0]       wb_dat_i;
    logic [7:0]       wb_dat_o;
    logic             wb_ack;

    int errors;
    int checks;

    // reference model of the field and the falling piece
    int field [ROWS][COLS];
    int m_row;
    int m_col;
    int m_type;

    tetris_core tetris_core_inst (
        .clk       (clk),
        .rst_l     (rst_l),
        .key_left  (keys_n[KEY_LEFT]),
        .key_right (keys_n[KEY_RIGHT]),
        .key_soft  (keys_n[KEY_SOFT]),
        .key_hard  (keys_n[KEY_HARD]),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void reset_model();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                field[r][c] = 0;
            end
        end
        m_row  = `SPAWN_ROW;
        m_col  = `SPAWN_COL;
        m_type = 1;
    endfunction

    function automatic bit piece_fits(input int r0, input int c0);
        int r;
        int c;
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            r = r0 + SHAPE_ROW[m_type][i];
            c = c0 + SHAPE_COL[m_type][i];
            if (r < 0 || r >= ROWS || c < 0 || c >= COLS) begin
                ok = 1'b0;
            end else if (field[r][c] != 0) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // falling piece drawn over the locked cells
    function automatic int expected_tile(input int r, input int c);
        int tile;
        tile = field[r][c];
        for (int i = 0; i < 4; i++) begin
            if (m_row + SHAPE_ROW[m_type][i] == r && m_col + SHAPE_COL[m_type][i] == c) begin
                tile = m_type;
            end
        end
        return tile;
    endfunction

    function automatic void lock_piece();
        for (int i = 0; i < 4; i++) begin
            field[m_row + SHAPE_ROW[m_type][i]][m_col + SHAPE_COL[m_type][i]] = m_type;
        end
        m_row  = `SPAWN_ROW;
        m_col  = `SPAWN_COL;
        // I O T S Z J L and back to I
        m_type = m_type % 7 + 1;
    endfunction

    function automatic void apply_action(input int action);
        case (action)
            KEY_LEFT: begin
                if (piece_fits(m_row, m_col - 1)) begin
                    m_col = m_col - 1;
                end
            end
            KEY_RIGHT: begin
                if (piece_fits(m_row, m_col + 1)) begin
                    m_col = m_col + 1;
                end
            end
            KEY_SOFT: begin
                if (piece_fits(m_row + 1, m_col)) begin
                    m_row = m_row + 1;
                end else begin
                    lock_piece();
                end
            end
            default: begin
                while (piece_fits(m_row + 1, m_col)) begin
                    m_row = m_row + 1;
                end
                lock_piece();
            end
        endcase
    endfunction

    task automatic end_simulation();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic wb_transfer(input logic we, input int row, input int col,
                               input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = ADR_W'(row * 16 + col);
        wb_dat_i = wdata;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) begin
            $display("wishbone ack did not arrive within %0d cycles at row %0d col %0d",
                     ACK_TIMEOUT, row, col);
            errors++;
            end_simulation();
        end else begin
            // ack follows the first edge that sees the strobe
            checks++;
            assert (waited == 1) else begin
                errors++;
                $display("ERROR wb_ack latency in cycles: expected %h, got %h", 1, waited);
            end
        end
    endtask

    task automatic check_cell(input int row, input int col, input int expected);
        logic [7:0] data;
        wb_transfer(1'b0, row, col, 8'h00, data);
        checks++;
        assert (data == 8'(expected)) else begin
            errors++;
            $display("ERROR wb_dat_o row %0d col %0d: expected %h, got %h",
                     row, col, 8'(expected), data);
        end
    endtask

    task automatic compare_field();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                check_cell(r, c, expected_tile(r, c));
            end
        end
    endtask

    // hold a key, release it and let the cooldown run out
    task automatic press_key(input int action, input int hold);
        @(negedge clk);
        keys_n[action] = 1'b0;
        repeat (hold) @(negedge clk);
        keys_n[action] = 1'b1;
        repeat (2 * `COOLDOWN_CYCLES) @(negedge clk);
    endtask

    task automatic tap_key(input int action);
        press_key(action, 1);
        apply_action(action);
    endtask

    task automatic spawn_after_reset();
        compare_field();
    endtask

    task automatic short_moves();
        tap_key(KEY_RIGHT);
        compare_field();
        tap_key(KEY_LEFT);
        compare_field();
        // more presses than the wall allows
        repeat (6) tap_key(KEY_RIGHT);
        check_cell(m_row, COLS - 1, 1);
        compare_field();
    endtask

    task automatic held_key_repeat();
        logic [7:0] data;
        int found;
        int first;
        int moves;
        int start_col;
        start_col = m_col;
        press_key(KEY_LEFT, 3 * `COOLDOWN_CYCLES);
        found = 0;
        first = -1;
        for (int c = 0; c < COLS; c++) begin
            wb_transfer(1'b0, m_row, c, 8'h00, data);
            if (data == 8'(m_type)) begin
                found++;
                if (first < 0) begin
                    first = c;
                end
            end
        end
        checks++;
        assert (found == 4) else begin
            errors++;
            $display("ERROR piece cells in row %0d: expected %h, got %h", m_row, 4, found);
        end
        // I piece origin is one right of its leftmost cell
        moves = start_col - (first + 1);
        checks++;
        assert (moves > 1 && moves <= 4) else begin
            errors++;
            $display("held left key moved the piece %0d columns instead of 2 to 4", moves);
        end
        m_col = first + 1;
        compare_field();
    endtask

    task automatic hard_drop_lock();
        tap_key(KEY_HARD);
        compare_field();
    endtask

    task automatic soft_drop_stack();
        int presses;
        tap_key(KEY_SOFT);
        compare_field();
        presses = 0;
        while (piece_fits(m_row + 1, m_col) && presses < ROWS) begin
            tap_key(KEY_SOFT);
            presses++;
        end
        compare_field();
        // blocked soft drop locks and spawns the next piece
        tap_key(KEY_SOFT);
        compare_field();
    endtask

    task automatic writes_ignored();
        logic [7:0] unused;
        // one locked cell and one blank cell, both outside the falling piece
        wb_transfer(1'b1, ROWS - 1, `SPAWN_COL, 8'h07, unused);
        wb_transfer(1'b1, ROWS - 1, 0, 8'h05, unused);
        compare_field();
        check_cell(25, 4, 0);
        check_cell(3, 12, 0);
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        rst_l    = 1'b0;
        keys_n   = 4'hf;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = 8'h00;
        reset_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_l = 1'b1;

        spawn_after_reset();
        short_moves();
        held_key_repeat();
        hard_drop_lock();
        soft_drop_stack();
        writes_ignored();
        end_simulation();
    end

endmodule

// ==== tetris_core.f ====
+incdir+include
source/tetris_pkg.sv
source/input_conditioner.sv
source/move_validator.sv
source/falling_piece.sv
source/locked_playfield.sv
source/tetris_core.sv
test/tetris_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f tetris_core.f \
		--top-module tetris_tb -Mdir obj_dir -o tetris_sim

run: compile
	./obj_dir/tetris_sim | tee sim.log
	@! grep -q "Result: FAILED" sim.log
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
